/* mul_csr.sv */
`timescale 1ns/1ps

module mul_csr
  import mul_issue_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  wb_req_t     wb,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack,
  input  logic [4:0]  occupancy,
  input  logic        issued,
  output logic        issue_en
);

  logic            req;
  logic            wr;
  csr_addr_e       addr;
  logic [31:0]     issue_count;
  logic [31:0]     rd_data;

  assign req  = wb.cyc & wb.stb & !wb_ack;  // one ack per strobe
  assign wr   = req & wb.we;
  assign addr = csr_addr_e'(wb.adr);

  always_comb begin
    case (addr)
      reg_ctrl:  rd_data = {31'd0, issue_en};
      reg_occ:   rd_data = {27'd0, occupancy};
      reg_count: rd_data = issue_count;
      default:   rd_data = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack   <= 1'b0;
      issue_en <= 1'b1;
    end else begin
      wb_ack <= req;
      if (wr && addr == reg_ctrl) begin
        issue_en <= wb.dat_w[0];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_count <= '0;
    end else if (wr && addr == reg_count) begin
      issue_count <= '0;  // any write clears
    end else if (issued) begin
      issue_count <= issue_count + 32'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= rd_data;
    end
  end

  a_ack_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack
  ) else $error("wb_ack held for two cycles");

endmodule

/* mul_issue.f */
mul_issue_pkg.sv
mul_rs.sv
mul_unit.sv
mul_csr.sv
mul_issue_top.sv
mul_issue_checker.sv
tb_mul_issue.sv

/* mul_issue_checker.sv */
`timescale 1ns/1ps

module mul_issue_checker
  import mul_issue_pkg::*;
(
  input  logic        clk,
  input  bcast_t      result,
  input  logic        dispatch_ready,
  input  logic        wb_ack,
  input  logic [31:0] wb_dat_r,
  input  bcast_t      exp_result,    // valid pulses one new expectation
  input  logic        exp_rd_valid,
  input  logic        exp_rd_occ,
  input  logic [31:0] exp_rd_data,
  input  logic        test_end,
  input  logic [7:0]  test_id,
  output int          pending,
  output int          tests_run,
  output int          tests_failed,
  output int          errors
);

  logic            exp_set [2**tag_w];
  logic [xlen-1:0] exp_value [2**tag_w];
  logic            rd_wait;
  logic [31:0]     rd_exp;
  logic            rd_occ;
  logic            rd_ready;
  int              test_errs;

  initial begin
    foreach (exp_set[t]) exp_set[t] = 1'b0;
    rd_wait      = 1'b0;
    rd_exp       = '0;
    rd_occ       = 1'b0;
    rd_ready     = 1'b0;
    pending      = 0;
    tests_run    = 0;
    tests_failed = 0;
    errors       = 0;
    test_errs    = 0;
  end

  task automatic note_error();
    test_errs++;
    errors++;
  endtask

  always @(posedge clk) begin
    if (result.valid) begin
      if (!exp_set[result.tag]) begin
        $display("result for tag %02h arrived with no expected value", result.tag);
        note_error();
      end else begin
        if (result.value !== exp_value[result.tag]) begin
          $display("FAIL result.value for tag %02h: expected %08h, got %08h",
                   result.tag, exp_value[result.tag], result.value);
          note_error();
        end
        exp_set[result.tag] = 1'b0;
        pending--;
      end
    end
    if (wb_ack && rd_wait) begin
      if (wb_dat_r !== rd_exp) begin
        $display("FAIL wb_dat_r: expected %08h, got %08h", rd_exp, wb_dat_r);
        note_error();
      end
      if (rd_occ && rd_ready !== (rd_exp < 32'(rs_depth))) begin
        $display("FAIL dispatch_ready: expected %h, got %h",
                 rd_exp < 32'(rs_depth), rd_ready);
        note_error();
      end
      rd_wait = 1'b0;
    end
    if (exp_rd_valid) begin
      rd_wait  = 1'b1;
      rd_exp   = exp_rd_data;
      rd_occ   = exp_rd_occ;
      rd_ready = dispatch_ready;  // same cycle the occupancy is read
    end
    if (exp_result.valid) begin
      if (!exp_set[exp_result.tag]) pending++;
      exp_set[exp_result.tag]   = 1'b1;
      exp_value[exp_result.tag] = exp_result.value;
    end
    if (test_end) begin
      for (int t = 0; t < 2**tag_w; t++) begin
        if (exp_set[t]) begin
          $display("test %0d: no result arrived for tag %02h", test_id, t);
          note_error();
          exp_set[t] = 1'b0;
        end
      end
      if (rd_wait) begin
        $display("test %0d: register read was never acknowledged", test_id);
        note_error();
        rd_wait = 1'b0;
      end
      pending = 0;
      tests_run++;
      if (test_errs != 0) begin
        tests_failed++;
        $display("test %0d failed with %0d errors", test_id, test_errs);
      end else begin
        $display("test %0d passed", test_id);
      end
      test_errs = 0;
    end
  end

endmodule

/* mul_issue_pkg.sv */
package mul_issue_pkg;

  localparam int rs_depth  = 16;
  localparam int rs_idx_w  = $clog2(rs_depth);
  localparam int tag_w     = 8;
  localparam int xlen      = 32;
  localparam int pc_w      = 32;
  localparam int num_bcast = 3;  // alu, div, load
  localparam int mul_lat   = 3;
  localparam int wb_adr_w  = 2;

  typedef enum logic [1:0] {
    op_mul    = 2'd0,
    op_mulh   = 2'd1,
    op_mulhsu = 2'd2,
    op_mulhu  = 2'd3
  } mul_op_e;

  typedef enum logic [wb_adr_w-1:0] {
    reg_ctrl  = 2'd0,
    reg_occ   = 2'd1,
    reg_count = 2'd2
  } csr_addr_e;

  typedef struct packed {
    logic [tag_w-1:0] tag;
    logic [xlen-1:0]  value;
    logic             ready;
  } src_t;

  typedef struct packed {
    logic             valid;
    logic [pc_w-1:0]  pc;
    logic [tag_w-1:0] rd;
    mul_op_e          op;
    src_t             src1;
    src_t             src2;
  } dispatch_t;

  typedef struct packed {
    logic             valid;
    logic [tag_w-1:0] tag;
    logic [xlen-1:0]  value;
  } bcast_t;

  typedef struct packed {
    logic             valid;
    logic [pc_w-1:0]  pc;
    logic [tag_w-1:0] rd;
    mul_op_e          op;
    logic [xlen-1:0]  a;
    logic [xlen-1:0]  b;
  } issue_t;

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [wb_adr_w-1:0] adr;
    logic [31:0]         dat_w;
  } wb_req_t;

endpackage

/* mul_issue_top.sv */
`timescale 1ns/1ps

module mul_issue_top
  import mul_issue_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush,
  input  dispatch_t              dispatch,
  output logic                   dispatch_ready,
  input  bcast_t [num_bcast-1:0] bcast,
  input  wb_req_t                wb,
  output logic [31:0]            wb_dat_r,
  output logic                   wb_ack,
  output bcast_t                 result
);

  issue_t     issue;
  logic       issue_en;
  logic       issued;
  logic [4:0] occupancy;

  mul_rs i_mul_rs (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .dispatch       (dispatch),
    .dispatch_ready (dispatch_ready),
    .bcast          (bcast),
    .mul_result     (result),  // multiplier wakes its own dependents
    .issue_en       (issue_en),
    .issue          (issue),
    .issued         (issued),
    .occupancy      (occupancy)
  );

  mul_unit i_mul_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .issue      (issue),
    .mul_result (result)
  );

  mul_csr i_mul_csr (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb        (wb),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .occupancy (occupancy),
    .issued    (issued),
    .issue_en  (issue_en)
  );

endmodule

/* mul_issue_trace.txt */
# D op rd pc tag1 val1 rdy1 tag2 val2 rdy2 [count] | B port tag val | E tag val [count]
# W adr data | R adr expected | F flush | N cycles | T test id   (all fields hex)
E 10 000b000f
E 11 ffffffff
E 12 fffffffe
E 13 fffffffd
D 0 10 100 00 00010003 1 00 00020005 1
D 1 11 104 00 fffffffd 1 00 00000007 1
D 2 12 108 00 fffffffe 1 00 ffffffff 1
D 3 13 10c 00 fffffffe 1 00 ffffffff 1
T 1
E 20 55
E 21 300
E 22 2a
E 23 54
D 0 20 200 30 0 0 00 5 1
N 2
B 1 30 11
N 1
B 2 31 100
D 0 21 204 31 0 0 00 3 1
D 0 22 208 00 6 1 00 7 1
D 0 23 20c 22 0 0 00 2 1
T 2
E 50 20 10
E 60 51
D 0 50 300 40 0 0 00 2 1 10
R 1 10
B 0 40 10
D 0 60 340 00 9 1 00 9 1
T 3
W 2 0
W 0 0
D 0 80 400 00 3 1 00 5 1 3
N 8
R 1 3
E 80 f 3
W 0 1
N 8
R 2 3
T 4
D 0 70 500 77 0 0 00 1 1 3
N 2
F
B 0 77 1234
N 4
R 1 0
E 73 10000
D 0 73 510 00 100 1 00 100 1
T 5

/* mul_rs.sv */
`timescale 1ns/1ps

module mul_rs
  import mul_issue_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush,
  input  dispatch_t               dispatch,
  output logic                    dispatch_ready,
  input  bcast_t [num_bcast-1:0]  bcast,
  input  bcast_t                  mul_result,
  input  logic                    issue_en,
  output issue_t                  issue,
  output logic                    issued,
  output logic [4:0]              occupancy
);

  logic [rs_depth-1:0]  entry_valid;
  logic [pc_w-1:0]      entry_pc [rs_depth];
  logic [tag_w-1:0]     entry_rd [rs_depth];
  mul_op_e              entry_op [rs_depth];
  src_t                 entry_src1 [rs_depth];
  src_t                 entry_src2 [rs_depth];

  bcast_t [num_bcast:0] wake_bus;
  logic [rs_depth-1:0]  entry_ready;
  logic                 free_found;
  logic [rs_idx_w-1:0]  free_idx;
  logic                 sel_found;
  logic [rs_idx_w-1:0]  sel_idx;
  logic                 disp_fire;
  logic                 do_issue;

  assign wake_bus = {mul_result, bcast};  // top slot is the multiplier

  // capture a broadcast value for a waiting operand
  function automatic src_t wake(input src_t s, input bcast_t [num_bcast:0] bus);
    src_t r;
    r = s;
    for (int k = 0; k <= num_bcast; k++) begin
      if (!r.ready && bus[k].valid && bus[k].tag == s.tag) begin
        r.ready = 1'b1;
        r.value = bus[k].value;
      end
    end
    return r;
  endfunction

  always_comb begin
    for (int i = 0; i < rs_depth; i++) begin
      entry_ready[i] = entry_valid[i] & entry_src1[i].ready & entry_src2[i].ready;
    end
  end

  // lowest free slot
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = rs_depth - 1; i >= 0; i--) begin
      if (!entry_valid[i]) begin
        free_found = 1'b1;
        free_idx   = rs_idx_w'(i);
      end
    end
  end

  // lowest ready slot
  always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int i = rs_depth - 1; i >= 0; i--) begin
      if (entry_ready[i]) begin
        sel_found = 1'b1;
        sel_idx   = rs_idx_w'(i);
      end
    end
  end

  always_comb begin
    occupancy = '0;
    for (int i = 0; i < rs_depth; i++) begin
      occupancy = occupancy + 5'(entry_valid[i]);
    end
  end

  assign dispatch_ready = free_found;
  assign disp_fire      = dispatch.valid & dispatch_ready;
  assign do_issue       = sel_found & issue_en;
  assign issued         = issue.valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      entry_valid <= '0;
    end else if (flush) begin
      entry_valid <= '0;
    end else begin
      for (int i = 0; i < rs_depth; i++) begin
        if (disp_fire && free_idx == rs_idx_w'(i)) begin
          entry_valid[i] <= 1'b1;
        end else if (do_issue && sel_idx == rs_idx_w'(i)) begin
          entry_valid[i] <= 1'b0;  // freed on the issue edge
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < rs_depth; i++) begin
      if (disp_fire && free_idx == rs_idx_w'(i)) begin
        entry_pc[i]   <= dispatch.pc;
        entry_rd[i]   <= dispatch.rd;
        entry_op[i]   <= dispatch.op;
        entry_src1[i] <= wake(dispatch.src1, wake_bus);  // same-cycle capture
        entry_src2[i] <= wake(dispatch.src2, wake_bus);
      end else begin
        entry_src1[i] <= wake(entry_src1[i], wake_bus);
        entry_src2[i] <= wake(entry_src2[i], wake_bus);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue <= '0;
    end else if (flush) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= do_issue;
      if (do_issue) begin
        issue.pc <= entry_pc[sel_idx];
        issue.rd <= entry_rd[sel_idx];
        issue.op <= entry_op[sel_idx];
        issue.a  <= entry_src1[sel_idx].value;
        issue.b  <= entry_src2[sel_idx].value;
      end
    end
  end

  // while full only an issue may change the entry count
  a_no_disp_when_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    (occupancy == 5'(rs_depth) && !flush) |=>
      occupancy == 5'(rs_depth) - 5'($past(do_issue))
  ) else $error("dispatch accepted with all entries occupied");

  a_issue_needs_en: assert property (
    @(posedge clk) disable iff (!rst_n)
    issue.valid |-> $past(issue_en) && !entry_valid[$past(sel_idx)]
  ) else $error("issue while issue_en was low or issued entry not freed");

endmodule

/* mul_unit.sv */
`timescale 1ns/1ps

module mul_unit
  import mul_issue_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   flush,
  input  issue_t issue,
  output bcast_t mul_result
);

  logic                     a_signed;
  logic                     b_signed;

  logic                     s1_valid;
  logic [tag_w-1:0]         s1_rd;
  mul_op_e                  s1_op;
  logic signed [xlen:0]     s1_a;  // one extra bit for sign/zero extension
  logic signed [xlen:0]     s1_b;

  logic                     s2_valid;
  logic [tag_w-1:0]         s2_rd;
  mul_op_e                  s2_op;
  logic [2*xlen-1:0]        s2_prod;

  logic                     s3_valid;
  logic [tag_w-1:0]         s3_tag;
  logic [xlen-1:0]          s3_value;

  assign a_signed = (issue.op == op_mulh) || (issue.op == op_mulhsu);
  assign b_signed = (issue.op == op_mulh);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else if (flush) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else begin
      s1_valid <= issue.valid;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_rd    <= issue.rd;
    s1_op    <= issue.op;
    s1_a     <= {a_signed & issue.a[xlen-1], issue.a};
    s1_b     <= {b_signed & issue.b[xlen-1], issue.b};
    s2_rd    <= s1_rd;
    s2_op    <= s1_op;
    s2_prod  <= s1_a * s1_b;
    s3_tag   <= s2_rd;
    s3_value <= (s2_op == op_mul) ? s2_prod[xlen-1:0] : s2_prod[2*xlen-1:xlen];
  end

  assign mul_result = '{valid: s3_valid, tag: s3_tag, value: s3_value};

  a_result_follows_issue: assert property (
    @(posedge clk) disable iff (!rst_n)
    mul_result.valid |-> mul_result.tag == $past(issue.rd, mul_lat) &&
      ($past(issue.op, mul_lat) != op_mul ||
       mul_result.value == $past(issue.a * issue.b, mul_lat))
  ) else $error("result tag or low product does not match the issued operation");

endmodule

/* tb_mul_issue.sv */
`timescale 1ns/1ps

module tb_mul_issue
  import mul_issue_pkg::*;
();

  logic                   clk;
  logic                   rst_n;
  logic                   flush;
  dispatch_t              dispatch;
  logic                   dispatch_ready;
  bcast_t [num_bcast-1:0] bcast;
  bcast_t [num_bcast-1:0] staged;  // goes out with the next cycle
  wb_req_t                wb;
  logic [31:0]            wb_dat_r;
  logic                   wb_ack;
  bcast_t                 result;
  bcast_t                 exp_result;
  logic                   exp_rd_valid;
  logic                   exp_rd_occ;
  logic [31:0]            exp_rd_data;
  logic                   test_end;
  logic [7:0]             test_id;
  int                     pending;
  int                     tests_run;
  int                     tests_failed;
  int                     errors;
  int                     trace_errors = 0;
  int                     cycles = 0;
  int                     limit = 0;
  string                  lines [$];

  mul_issue_top i_mul_issue_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .dispatch       (dispatch),
    .dispatch_ready (dispatch_ready),
    .bcast          (bcast),
    .wb             (wb),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack),
    .result         (result)
  );

  mul_issue_checker i_mul_issue_checker (
    .clk            (clk),
    .result         (result),
    .dispatch_ready (dispatch_ready),
    .wb_ack         (wb_ack),
    .wb_dat_r       (wb_dat_r),
    .exp_result     (exp_result),
    .exp_rd_valid   (exp_rd_valid),
    .exp_rd_occ     (exp_rd_occ),
    .exp_rd_data    (exp_rd_data),
    .test_end       (test_end),
    .test_id        (test_id),
    .pending        (pending),
    .tests_run      (tests_run),
    .tests_failed   (tests_failed),
    .errors         (errors)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: trace not finished after %0d cycles", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // one clock with the current drive, then drop the pulses
  task automatic advance_cycle();
    bcast = staged;
    @(posedge clk);
    #1;
    staged           = '0;
    bcast            = '0;
    dispatch.valid   = 1'b0;
    flush            = 1'b0;
    exp_result.valid = 1'b0;
    exp_rd_valid     = 1'b0;
    exp_rd_occ       = 1'b0;
    test_end         = 1'b0;
  endtask

  task automatic wb_cycle(input logic we, input logic [31:0] adr, input logic [31:0] data);
    wb.cyc   = 1'b1;
    wb.stb   = 1'b1;
    wb.we    = we;
    wb.adr   = adr[wb_adr_w-1:0];
    wb.dat_w = data;
    advance_cycle();
    while (!wb_ack) advance_cycle();
    wb = '0;
  endtask

  task automatic run_line(input string line);
    byte         cmd;
    logic [31:0] f [10];
    int          reps;
    foreach (f[i]) f[i] = '0;
    if (line.len() < 2 || line[0] == "#") return;
    void'($sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h", cmd,
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]));
    case (cmd)
      "D": begin
        reps = (f[9] == 0) ? 1 : f[9];
        for (int r = 0; r < reps; r++) begin
          while (!dispatch_ready) advance_cycle();  // station full
          dispatch.valid       = 1'b1;
          dispatch.pc          = f[2];
          dispatch.rd          = f[1][tag_w-1:0] + tag_w'(r);
          dispatch.op          = mul_op_e'(f[0][1:0]);
          dispatch.src1.tag    = f[3][tag_w-1:0];
          dispatch.src1.value  = f[4];
          dispatch.src1.ready  = f[5][0];
          dispatch.src2.tag    = f[6][tag_w-1:0];
          dispatch.src2.value  = f[7];
          dispatch.src2.ready  = f[8][0];
          advance_cycle();
        end
      end
      "B": begin
        staged[f[0][1:0]].valid = 1'b1;
        staged[f[0][1:0]].tag   = f[1][tag_w-1:0];
        staged[f[0][1:0]].value = f[2];
      end
      "E": begin
        reps = (f[2] == 0) ? 1 : f[2];
        for (int r = 0; r < reps; r++) begin
          exp_result.valid = 1'b1;
          exp_result.tag   = f[0][tag_w-1:0] + tag_w'(r);
          exp_result.value = f[1];
          advance_cycle();
        end
      end
      "W": wb_cycle(1'b1, f[0], f[1]);
      "R": begin
        exp_rd_valid = 1'b1;
        exp_rd_occ   = (f[0][wb_adr_w-1:0] == reg_occ);
        exp_rd_data  = f[1];
        wb_cycle(1'b0, f[0], '0);
      end
      "F": begin
        flush = 1'b1;
        advance_cycle();
      end
      "N": repeat (f[0]) advance_cycle();
      "T": begin
        for (int k = 0; k < 100 && pending != 0; k++) advance_cycle();
        test_id  = f[0][7:0];
        test_end = 1'b1;
        advance_cycle();
      end
      default: begin
        $display("unknown command in trace line: %s", line);
        trace_errors++;
      end
    endcase
  endtask

  initial begin
    int    fd;
    string line;
    rst_n        = 1'b0;
    flush        = 1'b0;
    dispatch     = '0;
    bcast        = '0;
    staged       = '0;
    wb           = '0;
    exp_result   = '0;
    exp_rd_valid = 1'b0;
    exp_rd_occ   = 1'b0;
    exp_rd_data  = '0;
    test_end     = 1'b0;
    test_id      = '0;
    fd = $fopen("mul_issue_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open mul_issue_trace.txt");
      $display("STATUS: FAIL");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0) lines.push_back(line);
      end
      $fclose(fd);
      limit = lines.size() * 20 + 200;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      foreach (lines[i]) run_line(lines[i]);
      repeat (4) advance_cycle();
      $display("tests run %0d, failed %0d, errors %0d",
               tests_run, tests_failed, errors + trace_errors);
      if (errors == 0 && trace_errors == 0 && tests_run > 0) begin
        $display("STATUS: PASS");
      end else begin
        $display("STATUS: FAIL");
      end
      $finish;
    end
  end

endmodule
